//--- Makefile
# Verilator build and run for the protocol negotiation testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
SIM_BIN   ?= $(OBJ_DIR)/V$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dstrm_mux.sv
/*
  Downstream overlay. While negotiating, writes the local handshake and
  protocol code into every segment, otherwise forwards the word unchanged
*/

`timescale 1ns/1ps

module dstrm_mux import neg_pkg::*; (
  input  logic                 negotiation_link_up,
  input  local_hs_t            local_hs,
  input  logic [BUS_WIDTH-1:0] ctrl_dstrm_data,
  output logic [BUS_WIDTH-1:0] txrx_dstrm_data
);

  // Every segment carries the same fields so the remote die can align
  // on whichever segment it likes
  for (genvar i = 0; i < SEG_COUNT; i++) begin : g_seg
    seg_word_u seg_in;
    seg_word_u seg_out;

    assign seg_in.raw = ctrl_dstrm_data[i*SEG_WIDTH +: SEG_WIDTH];

    always_comb begin
      seg_out = seg_in;
      // Payload bits above the handshake fields always pass through
      if (!negotiation_link_up) begin
        seg_out.fields.req  = local_hs.req;
        seg_out.fields.ack  = local_hs.ack;
        seg_out.fields.prot = LOCAL_PROTOCOL;
      end
    end

    assign txrx_dstrm_data[i*SEG_WIDTH +: SEG_WIDTH] = seg_out.raw;
  end

endmodule

//--- link_negotiator.sv
/*
  Negotiation FSM. Runs the req/ack handshake with the remote die, raises
  negotiation link-up once the handshake has settled and owns the
  side-band status flags
*/

`timescale 1ns/1ps

module link_negotiator import neg_pkg::*; (
  input  logic       lclk,
  input  logic       reset,
  input  logic       ctl_link_up,
  input  logic       renegotiate_n,
  input  remote_hs_t remote,
  output local_hs_t  local_hs,
  output logic       negotiation_link_up,
  output logic       neg_capture,
  output logic       neg_clear,
  output logic       pl_inband_pres,
  output logic       pl_portmode,
  output logic       pl_portmode_val
);

  neg_state_e state;
  neg_state_e state_nxt;
  logic       link_start;
  logic       ack_window;

  // Both the FSM and the side-band flags start from the same condition
  assign link_start = ctl_link_up & renegotiate_n;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge lclk or negedge reset) begin
    if (!reset) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (link_start) begin
          state_nxt = ST_WAIT_ACK;
        end
      end
      // The remote die must both request and acknowledge our request
      ST_WAIT_ACK: begin
        if (remote.req && remote.ack) begin
          state_nxt = ST_NEGOTIATE;
        end
      end
      ST_NEGOTIATE: state_nxt = ST_WAIT_NACK;
      // Now both remote bits have to fall before moving on
      ST_WAIT_NACK: begin
        if (!remote.req && !remote.ack) begin
          state_nxt = ST_QUIET1;
        end
      end
      ST_QUIET1: state_nxt = ST_QUIET2;
      ST_QUIET2: state_nxt = ST_DONE;
      ST_DONE: begin
        if (!renegotiate_n) begin
          state_nxt = ST_IDLE;
        end
      end
      // The unused encoding falls back to idle
      default: state_nxt = ST_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Handshake and state indicators
  //////////////////////////////////////////////////////////////////////

  // Our ack follows the remote req for as long as the handshake is open
  assign ack_window = (state == ST_WAIT_ACK)  || (state == ST_NEGOTIATE) ||
                      (state == ST_WAIT_NACK) || (state == ST_QUIET1)    ||
                      (state == ST_QUIET2);

  assign local_hs.req = (state == ST_WAIT_ACK) || (state == ST_NEGOTIATE);
  assign local_hs.ack = ack_window & remote.req;

  assign negotiation_link_up = (state == ST_DONE);
  assign neg_capture         = (state == ST_NEGOTIATE);
  assign neg_clear           = (state == ST_IDLE);

  //////////////////////////////////////////////////////////////////////
  // Side-band status flags
  //////////////////////////////////////////////////////////////////////

  // Renegotiation wins over link-up, all three flags move together
  always_ff @(posedge lclk or negedge reset) begin
    if (!reset) begin
      pl_inband_pres  <= 1'b0;
      pl_portmode     <= 1'b0;
      pl_portmode_val <= 1'b0;
    end else if (!renegotiate_n) begin
      pl_inband_pres  <= 1'b0;
      pl_portmode     <= 1'b0;
      pl_portmode_val <= 1'b0;
    end else if (link_start) begin
      pl_inband_pres  <= 1'b1;
      pl_portmode     <= 1'b1;
      pl_portmode_val <= 1'b1;
    end
  end

endmodule

//--- lpif_neg_top.sv
/*
  Link-layer protocol negotiation top level. Decodes the remote handshake
  from upstream segment 0, ties together the FSM, the protocol resolver
  and the downstream overlay, and passes upstream data straight through
*/

`timescale 1ns/1ps

module lpif_neg_top import neg_pkg::*; (
  input  logic                  lclk,
  input  logic                  reset,
  input  logic                  ctl_link_up,
  input  logic                  renegotiate_n,
  input  logic [BUS_WIDTH-1:0]  txrx_ustrm_data,
  input  logic [BUS_WIDTH-1:0]  ctrl_dstrm_data,
  output logic [BUS_WIDTH-1:0]  ctrl_ustrm_data,
  output logic [BUS_WIDTH-1:0]  txrx_dstrm_data,
  output logic                  negotiation_link_up,
  output logic [PROT_WIDTH-1:0] pl_protocol,
  output logic                  pl_protocol_vld,
  output logic                  pl_inband_pres,
  output logic                  pl_portmode,
  output logic                  pl_portmode_val
);

  seg_word_u  ustrm_seg0;
  remote_hs_t remote;
  local_hs_t  local_hs;
  logic       neg_capture;
  logic       neg_clear;

  // Upstream data is never touched; link-up qualifies it downstream of here
  assign ctrl_ustrm_data = txrx_ustrm_data;

  // The remote die replicates its fields in every segment, so the low one is enough
  assign ustrm_seg0.raw = txrx_ustrm_data[SEG_WIDTH-1:0];
  assign remote.req     = ustrm_seg0.fields.req;
  assign remote.ack     = ustrm_seg0.fields.ack;
  assign remote.prot    = ustrm_seg0.fields.prot;

  link_negotiator u_negotiator (
    .lclk                (lclk),
    .reset               (reset),
    .ctl_link_up         (ctl_link_up),
    .renegotiate_n       (renegotiate_n),
    .remote              (remote),
    .local_hs            (local_hs),
    .negotiation_link_up (negotiation_link_up),
    .neg_capture         (neg_capture),
    .neg_clear           (neg_clear),
    .pl_inband_pres      (pl_inband_pres),
    .pl_portmode         (pl_portmode),
    .pl_portmode_val     (pl_portmode_val)
  );

  prot_resolver u_resolver (
    .lclk            (lclk),
    .reset           (reset),
    .neg_capture     (neg_capture),
    .neg_clear       (neg_clear),
    .remote_prot     (remote.prot),
    .pl_protocol     (pl_protocol),
    .pl_protocol_vld (pl_protocol_vld)
  );

  dstrm_mux u_dstrm_mux (
    .negotiation_link_up (negotiation_link_up),
    .local_hs            (local_hs),
    .ctrl_dstrm_data     (ctrl_dstrm_data),
    .txrx_dstrm_data     (txrx_dstrm_data)
  );

endmodule

//--- neg_pkg.sv
/*
  Shared definitions for the die-to-die link-layer protocol negotiation
  block: bus and segment widths, the fixed local protocol and role, the
  negotiation FSM state encoding and the segment word layouts
*/

package neg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Link configuration
  //////////////////////////////////////////////////////////////////////

  // Second generation at half rate gives a 256-bit word of two 128-bit segments
  localparam int BUS_WIDTH  = 256;
  localparam int SEG_COUNT  = 2;
  localparam int SEG_WIDTH  = BUS_WIDTH / SEG_COUNT;
  localparam int PROT_WIDTH = 3;

  // This side is a device that offers protocol code 4
  localparam logic [PROT_WIDTH-1:0] LOCAL_PROTOCOL = 3'd4;
  localparam logic                  IS_HOST        = 1'b0;

  // Result reported when the code pair has no table entry
  localparam logic [PROT_WIDTH-1:0] PROT_DEFAULT   = 3'd3;

  //////////////////////////////////////////////////////////////////////
  // Negotiation FSM states
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    ST_IDLE      = 3'd0,
    // Local req is up, waiting for the remote req and ack
    ST_WAIT_ACK  = 3'd1,
    // Single cycle in which the protocol result is captured
    ST_NEGOTIATE = 3'd2,
    // Local req is down, waiting for the remote req and ack to drop
    ST_WAIT_NACK = 3'd3,
    // Two quiet cycles so the remote die sees our ack low
    ST_QUIET1    = 3'd4,
    ST_QUIET2    = 3'd5,
    // Data path handed back to normal traffic
    ST_DONE      = 3'd6
  } neg_state_e;

  //////////////////////////////////////////////////////////////////////
  // Segment layouts
  //////////////////////////////////////////////////////////////////////

  // Negotiation view of one segment, req sits in bit 0
  typedef struct packed {
    logic [SEG_WIDTH-PROT_WIDTH-3:0] payload;
    logic [PROT_WIDTH-1:0]           prot;
    logic                            ack;
    logic                            req;
  } neg_fields_t;

  // The same segment seen either as handshake fields or as raw payload
  typedef union packed {
    neg_fields_t          fields;
    logic [SEG_WIDTH-1:0] raw;
  } seg_word_u;

  // Handshake bits generated by this side
  typedef struct packed {
    logic ack;
    logic req;
  } local_hs_t;

  // Handshake bits and protocol code received from the remote die
  typedef struct packed {
    logic [PROT_WIDTH-1:0] prot;
    logic                  ack;
    logic                  req;
  } remote_hs_t;

endpackage

//--- project.f
neg_pkg.sv
link_negotiator.sv
prot_resolver.sv
dstrm_mux.sv
lpif_neg_top.sv
tb_clock.sv
tb_properties.sv
tb_top.sv

//--- prot_resolver.sv
/*
  Protocol resolver. Orders the local and remote codes into host and
  device, looks the pair up in the compatibility table and registers the
  agreed protocol when the FSM passes through negotiate
*/

`timescale 1ns/1ps

module prot_resolver import neg_pkg::*; (
  input  logic                  lclk,
  input  logic                  reset,
  input  logic                  neg_capture,
  input  logic                  neg_clear,
  input  logic [PROT_WIDTH-1:0] remote_prot,
  output logic [PROT_WIDTH-1:0] pl_protocol,
  output logic                  pl_protocol_vld
);

  logic [PROT_WIDTH-1:0] host_prot;
  logic [PROT_WIDTH-1:0] device_prot;
  logic [PROT_WIDTH-1:0] prot_nxt;
  logic                  vld_nxt;
  logic                  host_ok;
  logic                  device_ok;

  // The table is written from the host side, so put the codes in that order
  assign host_prot   = IS_HOST ? LOCAL_PROTOCOL : remote_prot;
  assign device_prot = IS_HOST ? remote_prot : LOCAL_PROTOCOL;

  // Only codes 3 to 7 name a real protocol
  assign host_ok   = (host_prot >= 3'd3);
  assign device_ok = (device_prot >= 3'd3);

  //////////////////////////////////////////////////////////////////////
  // Compatibility table
  //////////////////////////////////////////////////////////////////////

  // Code 3 is single mode and always wins. Code 4 wins over the second
  // generation multi modes but cannot pair with 7, which drops to 3.
  // Among 5, 6 and 7 the single mode 7 wins, else the larger code
  always_comb begin
    vld_nxt  = 1'b1;
    prot_nxt = PROT_DEFAULT;
    if (!host_ok || !device_ok) begin
      vld_nxt  = 1'b0;
      prot_nxt = PROT_DEFAULT;
    end else if ((host_prot == 3'd3) || (device_prot == 3'd3)) begin
      prot_nxt = 3'd3;
    end else if (((host_prot == 3'd4) && (device_prot == 3'd7)) ||
                 ((host_prot == 3'd7) && (device_prot == 3'd4))) begin
      prot_nxt = 3'd3;
    end else if ((host_prot == 3'd4) || (device_prot == 3'd4)) begin
      prot_nxt = 3'd4;
    end else if ((host_prot == 3'd7) || (device_prot == 3'd7)) begin
      prot_nxt = 3'd7;
    end else if (host_prot > device_prot) begin
      prot_nxt = host_prot;
    end else begin
      prot_nxt = device_prot;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result register
  //////////////////////////////////////////////////////////////////////

  // Loaded on the edge that leaves negotiate and held until the FSM idles
  always_ff @(posedge lclk or negedge reset) begin
    if (!reset) begin
      pl_protocol_vld <= 1'b0;
      pl_protocol     <= '0;
    end else if (neg_clear) begin
      pl_protocol_vld <= 1'b0;
      pl_protocol     <= '0;
    end else if (neg_capture) begin
      pl_protocol_vld <= vld_nxt;
      pl_protocol     <= prot_nxt;
    end
  end

endmodule

//--- tb_clock.sv
/*
  Testbench clock and reset source. Free-running 20 ns clock and an
  active-low reset that is released on a falling edge after four cycles
*/

`timescale 1ns/1ps

module tb_clock (
  output logic lclk,
  output logic reset
);

  localparam int PERIOD       = 20;
  localparam int RESET_CYCLES = 4;

  initial begin
    // Reset goes low first so the DUT registers never run unreset
    reset = 1'b0;
    lclk  = 1'b1;
    fork
      forever #(PERIOD / 2) lclk = ~lclk;
      begin
        #(RESET_CYCLES * PERIOD);
        // Falling edge release keeps it clear of the DUT's rising edge
        @(negedge lclk);
        reset <= 1'b1;
      end
    join
  end

endmodule

//--- tb_properties.sv
/*
  Concurrent properties of the negotiation block, bound into the top
  level. Cover protocol valid at link-up, ack quiet after link-up and
  agreement of the side-band flags
*/

`timescale 1ns/1ps

module neg_properties import neg_pkg::*; (
  input logic       lclk,
  input logic       reset,
  input logic       negotiation_link_up,
  input logic       neg_capture,
  input logic       pl_protocol_vld,
  input logic       pl_inband_pres,
  input logic       pl_portmode,
  input logic       pl_portmode_val,
  input local_hs_t  local_hs,
  input remote_hs_t remote
);

  logic code_ok;

  // Remembers whether the remote code seen in negotiate was a real protocol
  always_ff @(posedge lclk or negedge reset) begin
    if (!reset) begin
      code_ok <= 1'b0;
    end else if (neg_capture) begin
      code_ok <= (remote.prot >= 3'd3);
    end
  end

  a_vld_at_link_up: assert property (@(posedge lclk) disable iff (!reset)
    (negotiation_link_up && code_ok) |-> pl_protocol_vld)
    else $error("link-up with a valid remote code but no valid protocol");

  // Traffic owns the low bits once link-up is high
  a_no_ack_after_link_up: assert property (@(posedge lclk) disable iff (!reset)
    !(negotiation_link_up && local_hs.ack))
    else $error("local ack high while negotiation link-up is high");

  a_flags_agree: assert property (@(posedge lclk) disable iff (!reset)
    (pl_inband_pres == pl_portmode) && (pl_portmode == pl_portmode_val))
    else $error("side-band flags disagree");

endmodule

bind lpif_neg_top neg_properties u_props (
  .lclk                (lclk),
  .reset               (reset),
  .negotiation_link_up (negotiation_link_up),
  .neg_capture         (neg_capture),
  .pl_protocol_vld     (pl_protocol_vld),
  .pl_inband_pres      (pl_inband_pres),
  .pl_portmode         (pl_portmode),
  .pl_portmode_val     (pl_portmode_val),
  .local_hs            (local_hs),
  .remote              (remote)
);

//--- tb_top.sv
/*
  Testbench for the link-layer protocol negotiation block. Models the
  remote die, predicts the DUT outputs cycle by cycle and runs one full
  negotiation followed by a renegotiation for every remote protocol code
*/

`timescale 1ns/1ps

module tb_top import neg_pkg::*; ();

  // One opening negotiation plus one per remote code 0 to 7
  localparam int NUM_NEG     = 9;
  localparam int CYCLE_LIMIT = 40 * NUM_NEG + 100;

  logic                  lclk;
  logic                  reset;
  logic                  ctl_link_up;
  logic                  renegotiate_n;
  logic [BUS_WIDTH-1:0]  txrx_ustrm_data;
  logic [BUS_WIDTH-1:0]  ctrl_dstrm_data;
  logic [BUS_WIDTH-1:0]  ctrl_ustrm_data;
  logic [BUS_WIDTH-1:0]  txrx_dstrm_data;
  logic                  negotiation_link_up;
  logic [PROT_WIDTH-1:0] pl_protocol;
  logic                  pl_protocol_vld;
  logic                  pl_inband_pres;
  logic                  pl_portmode;
  logic                  pl_portmode_val;

  integer                seed = 32'hc44e_0e71;
  int                    err_cnt = 0;
  int                    check_cnt = 0;
  int                    cycle_cnt = 0;
  logic                  remote_up = 1'b0;
  logic [PROT_WIDTH-1:0] remote_code = LOCAL_PROTOCOL;

  // Predicted DUT state and outputs
  neg_state_e            pred;
  logic                  exp_req;
  logic                  exp_ack;
  logic                  exp_vld;
  logic [PROT_WIDTH-1:0] exp_prot;
  logic                  exp_flag;
  logic                  up_req;
  logic                  up_ack;
  logic [PROT_WIDTH-1:0] up_prot;
  logic [SEG_WIDTH-1:0]  exp_seg;

  tb_clock u_clock (
    .lclk  (lclk),
    .reset (reset)
  );

  lpif_neg_top dut0 (
    .lclk                (lclk),
    .reset               (reset),
    .ctl_link_up         (ctl_link_up),
    .renegotiate_n       (renegotiate_n),
    .txrx_ustrm_data     (txrx_ustrm_data),
    .ctrl_dstrm_data     (ctrl_dstrm_data),
    .ctrl_ustrm_data     (ctrl_ustrm_data),
    .txrx_dstrm_data     (txrx_dstrm_data),
    .negotiation_link_up (negotiation_link_up),
    .pl_protocol         (pl_protocol),
    .pl_protocol_vld     (pl_protocol_vld),
    .pl_inband_pres      (pl_inband_pres),
    .pl_portmode         (pl_portmode),
    .pl_portmode_val     (pl_portmode_val)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model and check helpers
  //////////////////////////////////////////////////////////////////////

  // Compatibility table, returns {valid, protocol}
  function automatic logic [PROT_WIDTH:0] ref_resolve(input logic [PROT_WIDTH-1:0] host,
                                                      input logic [PROT_WIDTH-1:0] dev);
    if (host < 3'd3 || dev < 3'd3) begin
      return {1'b0, PROT_DEFAULT};
    end
    if (host == 3'd3 || dev == 3'd3) begin
      return {1'b1, 3'd3};
    end
    // 4 and 7 cannot run together and fall back to 3
    if ((host == 3'd4 && dev == 3'd7) || (host == 3'd7 && dev == 3'd4)) begin
      return {1'b1, 3'd3};
    end
    if (host == 3'd4 || dev == 3'd4) begin
      return {1'b1, 3'd4};
    end
    if (host == 3'd7 || dev == 3'd7) begin
      return {1'b1, 3'd7};
    end
    return {1'b1, (host > dev) ? host : dev};
  endfunction

  task automatic check_value(input string name, input logic [BUS_WIDTH-1:0] got,
                             input logic [BUS_WIDTH-1:0] exp);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("[ERROR] %0t %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic check_idle_outputs();
    check_value("negotiation_link_up", BUS_WIDTH'(negotiation_link_up), '0);
    check_value("pl_protocol_vld", BUS_WIDTH'(pl_protocol_vld), '0);
    check_value("pl_protocol", BUS_WIDTH'(pl_protocol), '0);
    check_value("side-band flags",
                BUS_WIDTH'({pl_inband_pres, pl_portmode, pl_portmode_val}), '0);
  endtask

  // Brings the link up with the remote die offering code, then renegotiates
  task automatic run_negotiation(input logic [PROT_WIDTH-1:0] code);
    logic [PROT_WIDTH:0] exp_res;
    remote_code   <= code;
    ctl_link_up   <= 1'b1;
    renegotiate_n <= 1'b1;
    @(negedge lclk);
    check_value("side-band flags",
                BUS_WIDTH'({pl_inband_pres, pl_portmode, pl_portmode_val}), BUS_WIDTH'(3'b111));
    // DUT req travels in bit 0 of segment 0
    while (!txrx_dstrm_data[0]) @(negedge lclk);
    while (txrx_dstrm_data[0]) @(negedge lclk);
    exp_res = ref_resolve(code, LOCAL_PROTOCOL);
    check_value("pl_protocol", BUS_WIDTH'(pl_protocol), BUS_WIDTH'(exp_res[PROT_WIDTH-1:0]));
    check_value("pl_protocol_vld", BUS_WIDTH'(pl_protocol_vld), BUS_WIDTH'(exp_res[PROT_WIDTH]));
    // The remote model drops req and ack on this edge, link-up follows 3 edges later
    repeat (2) begin
      @(negedge lclk);
      check_value("negotiation_link_up", BUS_WIDTH'(negotiation_link_up), '0);
    end
    @(negedge lclk);
    check_value("negotiation_link_up", BUS_WIDTH'(negotiation_link_up), BUS_WIDTH'(1'b1));
    @(negedge lclk);
    renegotiate_n <= 1'b0;
    @(negedge lclk);
    check_value("negotiation_link_up", BUS_WIDTH'(negotiation_link_up), '0);
    check_value("side-band flags",
                BUS_WIDTH'({pl_inband_pres, pl_portmode, pl_portmode_val}), '0);
    @(negedge lclk);
    check_value("pl_protocol_vld", BUS_WIDTH'(pl_protocol_vld), '0);
    check_value("pl_protocol", BUS_WIDTH'(pl_protocol), '0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus, remote die model and cycle-by-cycle compare
  //////////////////////////////////////////////////////////////////////

  // Random payloads every cycle, remote handshake overlaid on segment 0
  always @(negedge lclk) begin
    logic [BUS_WIDTH-1:0] up_word;
    logic [BUS_WIDTH-1:0] dn_word;
    logic                 nxt_up;
    for (int k = 0; k < BUS_WIDTH / 32; k++) begin
      up_word[k*32 +: 32] = $random(seed);
      dn_word[k*32 +: 32] = $random(seed);
    end
    nxt_up = remote_up;
    if (!remote_up && !negotiation_link_up && txrx_dstrm_data[0]) begin
      nxt_up = 1'b1;
    end else if (remote_up && !txrx_dstrm_data[0]) begin
      nxt_up = 1'b0;
    end
    // After link-up the low bits are ordinary traffic and may look like a req
    if (!negotiation_link_up) begin
      up_word[0]   = nxt_up;
      up_word[1]   = nxt_up;
      up_word[4:2] = remote_code;
    end
    remote_up       <= nxt_up;
    txrx_ustrm_data <= up_word;
    ctrl_dstrm_data <= dn_word;
  end

  // Inputs still hold what the last rising edge saw, so step the prediction first
  always @(negedge lclk) begin
    up_req  = txrx_ustrm_data[0];
    up_ack  = txrx_ustrm_data[1];
    up_prot = txrx_ustrm_data[4:2];
    if (!reset) begin
      pred     = ST_IDLE;
      exp_vld  = 1'b0;
      exp_prot = '0;
      exp_flag = 1'b0;
    end else begin
      if (pred == ST_IDLE) begin
        {exp_vld, exp_prot} = '0;
      end else if (pred == ST_NEGOTIATE) begin
        {exp_vld, exp_prot} = ref_resolve(up_prot, LOCAL_PROTOCOL);
      end
      if (!renegotiate_n) begin
        exp_flag = 1'b0;
      end else if (ctl_link_up) begin
        exp_flag = 1'b1;
      end
      case (pred)
        ST_IDLE:      if (ctl_link_up && renegotiate_n) pred = ST_WAIT_ACK;
        ST_WAIT_ACK:  if (up_req && up_ack) pred = ST_NEGOTIATE;
        ST_NEGOTIATE: pred = ST_WAIT_NACK;
        ST_WAIT_NACK: if (!up_req && !up_ack) pred = ST_QUIET1;
        ST_QUIET1:    pred = ST_QUIET2;
        ST_QUIET2:    pred = ST_DONE;
        ST_DONE:      if (!renegotiate_n) pred = ST_IDLE;
        default:      pred = ST_IDLE;
      endcase
    end
    exp_req = (pred == ST_WAIT_ACK) || (pred == ST_NEGOTIATE);
    exp_ack = up_req && (pred inside {ST_WAIT_ACK, ST_NEGOTIATE, ST_WAIT_NACK,
                                      ST_QUIET1, ST_QUIET2});
    check_value("negotiation_link_up", BUS_WIDTH'(negotiation_link_up),
                BUS_WIDTH'(pred == ST_DONE));
    check_value("pl_protocol_vld", BUS_WIDTH'(pl_protocol_vld), BUS_WIDTH'(exp_vld));
    check_value("pl_protocol", BUS_WIDTH'(pl_protocol), BUS_WIDTH'(exp_prot));
    check_value("pl_inband_pres", BUS_WIDTH'(pl_inband_pres), BUS_WIDTH'(exp_flag));
    check_value("pl_portmode", BUS_WIDTH'(pl_portmode), BUS_WIDTH'(exp_flag));
    check_value("pl_portmode_val", BUS_WIDTH'(pl_portmode_val), BUS_WIDTH'(exp_flag));
    check_value("ctrl_ustrm_data", ctrl_ustrm_data, txrx_ustrm_data);
    if (pred == ST_DONE) begin
      check_value("txrx_dstrm_data", txrx_dstrm_data, ctrl_dstrm_data);
    end else begin
      for (int s = 0; s < SEG_COUNT; s++) begin
        exp_seg      = ctrl_dstrm_data[s*SEG_WIDTH +: SEG_WIDTH];
        exp_seg[0]   = exp_req;
        exp_seg[1]   = exp_ack;
        exp_seg[4:2] = LOCAL_PROTOCOL;
        check_value($sformatf("txrx_dstrm_data segment %0d", s),
                    BUS_WIDTH'(txrx_dstrm_data[s*SEG_WIDTH +: SEG_WIDTH]), BUS_WIDTH'(exp_seg));
      end
    end
  end

  // Watchdog sized from the number of negotiations
  always @(posedge lclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles, the negotiations never completed", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    ctl_link_up     = 1'b0;
    renegotiate_n   = 1'b1;
    txrx_ustrm_data = '0;
    ctrl_dstrm_data = '0;
    repeat (2) @(negedge lclk);
    check_idle_outputs();
    wait (reset === 1'b1);
    @(negedge lclk);
    check_idle_outputs();
    run_negotiation(LOCAL_PROTOCOL);
    for (int c = 0; c < 8; c++) begin
      run_negotiation(c[PROT_WIDTH-1:0]);
    end
    @(negedge lclk);
    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
